// File: rtl/dec_cfg.svh
/*
 * Decoder configuration: data and selector widths, opcode field positions
 */
`ifndef DEC_CFG_SVH
`define DEC_CFG_SVH

// Opcode and data bus width
`define DEC_DATA_WIDTH 8

// Operand and destination selector width
`define DEC_SEL_WIDTH 4

// Opcode layout is aaa_bbb_cc
`define DEC_MODE_LSB 2
`define DEC_OP_LSB 5

`endif

// File: rtl/cpu_isa_pkg.sv
/*
 * Instruction-set types of the 6502-style core: group-one addressing
 * modes and operations, and the implied opcodes the decoder handles
 */
`include "dec_cfg.svh"

package cpu_isa_pkg;

        typedef logic [`DEC_DATA_WIDTH-1:0] opcode_t;

        // Group one (cc = 01) addressing modes, bits 4:2
        typedef enum logic [2:0] {
                AM_X_IND = 3'b000,
                AM_ZPG   = 3'b001,
                AM_IMM   = 3'b010,
                AM_ABS   = 3'b011,
                AM_IND_Y = 3'b100,
                AM_ZPG_X = 3'b101,
                AM_ABS_Y = 3'b110,
                AM_ABS_X = 3'b111
        } addr_mode_e;

        // Group one operations, bits 7:5
        typedef enum logic [2:0] {
                OP_ORA = 3'b000,
                OP_AND = 3'b001,
                OP_EOR = 3'b010,
                OP_ADC = 3'b011,
                OP_STA = 3'b100,
                OP_LDA = 3'b101,
                OP_CMP = 3'b110,
                OP_SBC = 3'b111
        } grp1_op_e;

        // Register steps
        localparam opcode_t OPC_INX = 8'hE8;
        localparam opcode_t OPC_INY = 8'hC8;
        localparam opcode_t OPC_DEX = 8'hCA;
        localparam opcode_t OPC_DEY = 8'h88;

        // Carry flag
        localparam opcode_t OPC_CLC = 8'h18;
        localparam opcode_t OPC_SEC = 8'h38;

endpackage

// File: rtl/dec_ctrl_pkg.sv
/*
 * Control types of the decoder: ALU operations, operand and destination
 * selects, instruction classes and sequencer states
 */
`include "dec_cfg.svh"

package dec_ctrl_pkg;

        typedef enum logic [1:0] {
                ALU_OR  = 2'd0,
                ALU_AND = 2'd1,
                ALU_XOR = 2'd2,
                ALU_SUM = 2'd3
        } alu_op_e;

        typedef enum logic [`DEC_SEL_WIDTH-1:0] {
                SRC_ACC  = 4'h0,
                SRC_X    = 4'h1,
                SRC_Y    = 4'h2,
                SRC_MEM  = 4'h3,
                SRC_IMM  = 4'h4,
                SRC_ZERO = 4'h5,
                SRC_FF   = 4'h6,
                SRC_ALU  = 4'h7
        } src_sel_e;

        typedef enum logic [2:0] {
                CLS_ALU,
                CLS_LOAD,
                CLS_STORE,
                CLS_FLAG,
                CLS_NONE
        } insn_class_e;

        typedef enum logic [1:0] {
                SEQ_IDLE,
                SEQ_WAIT_ALU,
                SEQ_FINISH
        } seq_state_e;

endpackage

// File: rtl/dec_stage_if.sv
/*
 * Stage links of the decoder pipeline. An item moves on an edge
 * where valid is high and stall is low
 */
`timescale 1ns/1ps
`include "dec_cfg.svh"

// Predecode to microcode
interface predec_if;
        import cpu_isa_pkg::*;

        logic       valid;
        opcode_t    opcode;
        addr_mode_e mode;
        grp1_op_e   op;
        logic       grp1;
        logic       stall;

        modport producer (output valid, opcode, mode, op, grp1, input stall);
        modport consumer (input valid, opcode, mode, op, grp1, output stall);
endinterface

// Microcode to sequencer
interface ctrl_if;
        import dec_ctrl_pkg::*;

        logic        valid;
        insn_class_e cls;
        alu_op_e     alu_op;
        src_sel_e    a_sel;
        src_sel_e    b_sel;
        logic        carry_in;
        logic        invert_b;
        src_sel_e    dest;
        logic        writes_acc;
        logic        update_status;
        logic        carry_value;
        logic        stall;

        modport producer (output valid, cls, alu_op, a_sel, b_sel, carry_in, invert_b,
                          dest, writes_acc, update_status, carry_value, input stall);
        modport consumer (input valid, cls, alu_op, a_sel, b_sel, carry_in, invert_b,
                          dest, writes_acc, update_status, carry_value, output stall);
endinterface

// File: rtl/dec_predecode.sv
/*
 * Predecode stage: captures an opcode and splits it into mode and
 * operation fields, flagging group-one opcodes
 */
`timescale 1ns/1ps
`include "dec_cfg.svh"

module dec_predecode (
        input  logic                 clk,
        input  logic                 reset_n,
        input  logic                 instruction_ready,
        input  cpu_isa_pkg::opcode_t instruction_in,
        output logic                 ready,
        predec_if.producer           down
);
        import cpu_isa_pkg::*;

        logic take;

        // Stage can load when empty or when its item moves on
        assign ready = !down.valid || !down.stall;
        assign take  = instruction_ready && ready;

        always_ff @(posedge clk) begin
                if (!reset_n)
                        down.valid <= 1'b0;
                else if (ready)
                        down.valid <= instruction_ready;
        end

        always_ff @(posedge clk) begin
                if (take) begin
                        down.opcode <= instruction_in;
                        down.mode   <= addr_mode_e'(instruction_in[`DEC_MODE_LSB +: 3]);
                        down.op     <= grp1_op_e'(instruction_in[`DEC_OP_LSB +: 3]);
                        down.grp1   <= instruction_in[1:0] == 2'b01;
                end
        end

endmodule

// File: rtl/dec_microcode.sv
/*
 * Microcode stage: maps a predecoded opcode to the control word
 * used by the sequencer
 */
`timescale 1ns/1ps
`include "dec_cfg.svh"

module dec_microcode (
        input  logic       clk,
        input  logic       reset_n,
        predec_if.consumer up,
        ctrl_if.producer   down
);
        import cpu_isa_pkg::*;
        import dec_ctrl_pkg::*;

        logic     take;
        logic     step_inc;
        src_sel_e step_reg;

        // A held word also holds predecode
        assign up.stall = down.valid && down.stall;
        assign take     = up.valid && !up.stall;

        assign step_inc = up.opcode == OPC_INX || up.opcode == OPC_INY;
        assign step_reg = (up.opcode == OPC_INX || up.opcode == OPC_DEX) ? SRC_X : SRC_Y;

        always_ff @(posedge clk) begin
                if (!reset_n)
                        down.valid <= 1'b0;
                else if (!up.stall)
                        down.valid <= up.valid;
        end

        always_ff @(posedge clk) begin
                if (take) begin
                        down.cls           <= CLS_NONE;
                        down.alu_op        <= ALU_SUM;
                        down.a_sel         <= SRC_ACC;
                        down.b_sel         <= (up.mode == AM_IMM) ? SRC_IMM : SRC_MEM;
                        down.carry_in      <= 1'b0;
                        down.invert_b      <= 1'b0;
                        down.dest          <= SRC_ACC;
                        down.writes_acc    <= 1'b0;
                        down.update_status <= 1'b0;
                        down.carry_value   <= 1'b0;

                        if (up.grp1) begin
                                down.cls           <= CLS_ALU;
                                down.writes_acc    <= up.op != OP_CMP;
                                down.invert_b      <= up.op inside {OP_CMP, OP_SBC};
                                down.update_status <= up.op inside {OP_ADC, OP_CMP, OP_SBC};
                                case (up.op)
                                        OP_ORA: down.alu_op <= ALU_OR;
                                        OP_AND: down.alu_op <= ALU_AND;
                                        OP_EOR: down.alu_op <= ALU_XOR;
                                        OP_STA: begin
                                                // No store to an immediate
                                                down.cls <= (up.mode == AM_IMM) ? CLS_NONE
                                                                                 : CLS_STORE;
                                                down.dest       <= SRC_MEM;
                                                down.writes_acc <= 1'b0;
                                        end
                                        OP_LDA: down.cls <= CLS_LOAD;
                                        default: down.alu_op <= ALU_SUM;
                                endcase
                        end else begin
                                case (up.opcode)
                                        OPC_INX, OPC_INY, OPC_DEX, OPC_DEY: begin
                                                // Increment adds 0 plus carry, decrement adds FF
                                                down.cls           <= CLS_ALU;
                                                down.a_sel         <= step_reg;
                                                down.b_sel         <= step_inc ? SRC_ZERO : SRC_FF;
                                                down.carry_in      <= step_inc;
                                                down.dest          <= step_reg;
                                                down.update_status <= 1'b1;
                                        end
                                        OPC_CLC, OPC_SEC: begin
                                                down.cls         <= CLS_FLAG;
                                                down.carry_value <= up.opcode == OPC_SEC;
                                        end
                                        default: down.cls <= CLS_NONE;
                                endcase
                        end
                end
        end

endmodule

// File: rtl/dec_sequencer.sv
/*
 * Sequencer: issues each control word, waits on the ALU where needed
 * and pulses the writeback strobes and instruction_done
 */
`timescale 1ns/1ps
`include "dec_cfg.svh"

module dec_sequencer (
        input  logic                   clk,
        input  logic                   reset_n,
        ctrl_if.consumer               up,
        input  logic                   alu_done,
        output logic                   alu_start,
        output dec_ctrl_pkg::alu_op_e  alu_op,
        output dec_ctrl_pkg::src_sel_e alu_a_sel,
        output dec_ctrl_pkg::src_sel_e alu_b_sel,
        output logic                   carry_in,
        output logic                   invert_b,
        output logic                   we_acc,
        output logic                   we_x,
        output logic                   we_y,
        output logic                   we_stat,
        output logic                   we_mem,
        output dec_ctrl_pkg::src_sel_e dest_sel,
        output logic                   update_status,
        output logic                   carry_value,
        output logic                   instruction_done
);
        import dec_ctrl_pkg::*;

        seq_state_e state;
        src_sel_e   wb_dest;
        logic       wb_acc;
        logic       wb_status;
        logic       take;
        logic       alu_wb;

        // One bubble after each done keeps the done pulses apart
        assign up.stall = state != SEQ_IDLE || instruction_done;
        assign take     = up.valid && !up.stall;
        assign alu_wb   = state == SEQ_WAIT_ALU && alu_done;

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        state            <= SEQ_IDLE;
                        alu_start        <= 1'b0;
                        we_acc           <= 1'b0;
                        we_x             <= 1'b0;
                        we_y             <= 1'b0;
                        we_stat          <= 1'b0;
                        we_mem           <= 1'b0;
                        update_status    <= 1'b0;
                        instruction_done <= 1'b0;
                end else begin
                        alu_start        <= 1'b0;
                        we_acc           <= 1'b0;
                        we_x             <= 1'b0;
                        we_y             <= 1'b0;
                        we_stat          <= 1'b0;
                        we_mem           <= 1'b0;
                        update_status    <= 1'b0;
                        instruction_done <= 1'b0;
                        case (state)
                                SEQ_IDLE: begin
                                        if (take) begin
                                                case (up.cls)
                                                        CLS_ALU: begin
                                                                alu_start <= 1'b1;
                                                                state     <= SEQ_WAIT_ALU;
                                                        end
                                                        CLS_LOAD: begin
                                                                we_acc <= up.writes_acc;
                                                                state  <= SEQ_FINISH;
                                                        end
                                                        CLS_STORE: begin
                                                                we_mem <= 1'b1;
                                                                state  <= SEQ_FINISH;
                                                        end
                                                        CLS_FLAG: begin
                                                                we_stat <= 1'b1;
                                                                state   <= SEQ_FINISH;
                                                        end
                                                        default: instruction_done <= 1'b1;
                                                endcase
                                        end
                                end
                                SEQ_WAIT_ALU: begin
                                        if (alu_done) begin
                                                we_acc           <= wb_acc;
                                                we_x             <= wb_dest == SRC_X;
                                                we_y             <= wb_dest == SRC_Y;
                                                we_stat          <= wb_status;
                                                update_status    <= wb_status;
                                                instruction_done <= 1'b1;
                                                state            <= SEQ_IDLE;
                                        end
                                end
                                SEQ_FINISH: begin
                                        instruction_done <= 1'b1;
                                        state            <= SEQ_IDLE;
                                end
                                default: state <= SEQ_IDLE;
                        endcase
                end
        end

        // Word fields held for the whole instruction
        always_ff @(posedge clk) begin
                if (take) begin
                        alu_op      <= up.alu_op;
                        alu_a_sel   <= up.a_sel;
                        alu_b_sel   <= up.b_sel;
                        carry_in    <= up.carry_in;
                        invert_b    <= up.invert_b;
                        carry_value <= up.carry_value;
                        wb_dest     <= up.dest;
                        wb_acc      <= up.writes_acc;
                        wb_status   <= up.update_status;
                        // Store writes the accumulator, load takes imm or mem
                        dest_sel    <= (up.cls == CLS_STORE) ? up.a_sel : up.b_sel;
                end else if (alu_wb) begin
                        dest_sel <= SRC_ALU;
                end
        end

endmodule

// File: rtl/decoder_top.sv
/*
 * Instruction decoder top: predecode, microcode and sequencer stages
 */
`timescale 1ns/1ps
`include "dec_cfg.svh"

module decoder_top (
        input  logic                   clk,
        input  logic                   reset_n,
        input  logic                   instruction_ready,
        input  cpu_isa_pkg::opcode_t   instruction_in,
        input  logic                   alu_done,
        output logic                   ready,
        output logic                   alu_start,
        output dec_ctrl_pkg::alu_op_e  alu_op,
        output dec_ctrl_pkg::src_sel_e alu_a_sel,
        output dec_ctrl_pkg::src_sel_e alu_b_sel,
        output logic                   carry_in,
        output logic                   invert_b,
        output logic                   we_acc,
        output logic                   we_x,
        output logic                   we_y,
        output logic                   we_stat,
        output logic                   we_mem,
        output dec_ctrl_pkg::src_sel_e dest_sel,
        output logic                   update_status,
        output logic                   carry_value,
        output logic                   instruction_done
);
        predec_if pd_link ();
        ctrl_if   ct_link ();

        dec_predecode predecode_i (
                .clk               (clk),
                .reset_n           (reset_n),
                .instruction_ready (instruction_ready),
                .instruction_in    (instruction_in),
                .ready             (ready),
                .down              (pd_link)
        );

        dec_microcode microcode_i (
                .clk     (clk),
                .reset_n (reset_n),
                .up      (pd_link),
                .down    (ct_link)
        );

        dec_sequencer sequencer_i (
                .clk              (clk),
                .reset_n          (reset_n),
                .up               (ct_link),
                .alu_done         (alu_done),
                .alu_start        (alu_start),
                .alu_op           (alu_op),
                .alu_a_sel        (alu_a_sel),
                .alu_b_sel        (alu_b_sel),
                .carry_in         (carry_in),
                .invert_b         (invert_b),
                .we_acc           (we_acc),
                .we_x             (we_x),
                .we_y             (we_y),
                .we_stat          (we_stat),
                .we_mem           (we_mem),
                .dest_sel         (dest_sel),
                .update_status    (update_status),
                .carry_value      (carry_value),
                .instruction_done (instruction_done)
        );

endmodule

// File: test/dec_chk.sv
/*
 * Protocol checks on the decoder strobes, bound into decoder_top
 */
`timescale 1ns/1ps

module dec_chk (
        input logic clk,
        input logic reset_n,
        input logic alu_start,
        input logic alu_done,
        input logic we_acc,
        input logic we_x,
        input logic we_y,
        input logic we_stat,
        input logic we_mem,
        input logic instruction_done
);
        logic alu_pending;
        logic any_strobe;

        assign any_strobe = alu_start || we_acc || we_x || we_y || we_stat || we_mem ||
                            instruction_done;

        // ALU started and its done not yet seen
        always_ff @(posedge clk) begin
                if (!reset_n)
                        alu_pending <= 1'b0;
                else
                        alu_pending <= (alu_pending || alu_start) && !alu_done;
        end

        done_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
                instruction_done |=> !instruction_done)
                else $error("instruction_done held for more than one cycle");

        no_acc_before_done: assert property (@(posedge clk) disable iff (!reset_n)
                alu_pending |-> !we_acc)
                else $error("we_acc raised before alu_done");

        mem_acc_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
                !(we_mem && we_acc))
                else $error("we_mem and we_acc high together");

        quiet_in_reset: assert property (@(posedge clk)
                !reset_n |=> !any_strobe)
                else $error("strobe high while reset is held");

endmodule

bind decoder_top dec_chk chk_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .alu_start        (alu_start),
        .alu_done         (alu_done),
        .we_acc           (we_acc),
        .we_x             (we_x),
        .we_y             (we_y),
        .we_stat          (we_stat),
        .we_mem           (we_mem),
        .instruction_done (instruction_done)
);

// File: test/tb_decoder.sv
/*
 * Testbench for the instruction decoder: a table of opcodes with their
 * expected controls, an ALU with random latency and in-order output checks
 */
`timescale 1ns/1ps

module tb_decoder;
        import cpu_isa_pkg::*;
        import dec_ctrl_pkg::*;

        localparam int NROWS = 72;
        // Twelve cycles per row plus the reset
        localparam int LIMIT = NROWS * 12 + 16;

        typedef struct packed {
                opcode_t     opc;
                insn_class_e cls;
                alu_op_e     op;
                src_sel_e    a_sel;
                src_sel_e    b_sel;
                logic        inv;
                logic        cin;
                logic        upd;
                logic        cv;
                logic [4:0]  wr;
        } row_t;

        logic        clk;
        logic        reset_n;
        logic        instruction_ready;
        opcode_t     instruction_in;
        logic        alu_done;
        logic        ready;
        logic        alu_start;
        alu_op_e     alu_op;
        src_sel_e    alu_a_sel;
        src_sel_e    alu_b_sel;
        logic        carry_in;
        logic        invert_b;
        logic        we_acc;
        logic        we_x;
        logic        we_y;
        logic        we_stat;
        logic        we_mem;
        src_sel_e    dest_sel;
        logic        update_status;
        logic        carry_value;
        logic        instruction_done;

        row_t        rows[NROWS];
        row_t        pend_q[$];
        int          issue_q[$];
        int          nrow = 0;
        int          next_row = 0;
        int          done_count = 0;
        int          cyc = 0;
        int          alu_wait = 0;
        int          write_cyc = -100;
        logic        first_seen = 1'b0;
        logic        started = 1'b0;
        logic        alu_fired = 1'b0;
        int unsigned lcg_state = 32'd79056;

        decoder_top dut_i (.*);

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        always @(posedge clk) begin
                cyc <= cyc + 1;
                if (cyc >= LIMIT)
                        stop_with_failure($sformatf("ERROR: run hung, no finish in %0d cycles",
                                LIMIT));
        end

        task automatic stop_with_failure(input string msg);
                $display("%s", msg);
                $display("*** FAILED ***");
                $fatal(1, "simulation stopped");
        endtask

        task automatic value_error(input string msg);
                stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
        endtask

        function automatic int unsigned next_random();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state >> 16;
        endfunction

        // Flag bits are invert_b, carry_in, update_status and carry_value
        task automatic add_row(input opcode_t opc, input insn_class_e cls, input alu_op_e op,
                               input src_sel_e a_sel, input src_sel_e b_sel,
                               input logic [3:0] flags, input logic [4:0] wr);
                rows[nrow] = '{opc, cls, op, a_sel, b_sel, flags[3], flags[2], flags[1],
                               flags[0], wr};
                nrow++;
        endtask

        // Expands one operation over all eight addressing modes
        task automatic add_group_one(input grp1_op_e op, input insn_class_e cls,
                                     input alu_op_e aop, input logic [3:0] flags,
                                     input logic [4:0] wr);
                insn_class_e c;
                src_sel_e    b;
                logic [4:0]  w;
                for (int m = 0; m < 8; m++) begin
                        c = cls;
                        w = wr;
                        b = (m == 2) ? SRC_IMM : SRC_MEM;
                        if (cls == CLS_STORE) begin
                                b = SRC_ACC;
                                if (m == 2) begin
                                        c = CLS_NONE;
                                        w = 5'b00000;
                                end
                        end
                        add_row({op, m[2:0], 2'b01}, c, aop, SRC_ACC, b, flags, w);
                end
        endtask

        // Write strobes are ordered acc, x, y, stat, mem
        task automatic fill_table();
                add_group_one(OP_ORA, CLS_ALU,   ALU_OR,  4'b0000, 5'b10000);
                add_group_one(OP_AND, CLS_ALU,   ALU_AND, 4'b0000, 5'b10000);
                add_group_one(OP_EOR, CLS_ALU,   ALU_XOR, 4'b0000, 5'b10000);
                add_group_one(OP_ADC, CLS_ALU,   ALU_SUM, 4'b0010, 5'b10010);
                add_group_one(OP_STA, CLS_STORE, ALU_SUM, 4'b0000, 5'b00001);
                add_group_one(OP_LDA, CLS_LOAD,  ALU_SUM, 4'b0000, 5'b10000);
                add_group_one(OP_CMP, CLS_ALU,   ALU_SUM, 4'b1010, 5'b00010);
                add_group_one(OP_SBC, CLS_ALU,   ALU_SUM, 4'b1010, 5'b10010);
                add_row(OPC_INX, CLS_ALU,  ALU_SUM, SRC_X,   SRC_ZERO, 4'b0110, 5'b01010);
                add_row(OPC_INY, CLS_ALU,  ALU_SUM, SRC_Y,   SRC_ZERO, 4'b0110, 5'b00110);
                add_row(OPC_DEX, CLS_ALU,  ALU_SUM, SRC_X,   SRC_FF,   4'b0010, 5'b01010);
                add_row(OPC_DEY, CLS_ALU,  ALU_SUM, SRC_Y,   SRC_FF,   4'b0010, 5'b00110);
                add_row(OPC_CLC, CLS_FLAG, ALU_SUM, SRC_ACC, SRC_ACC,  4'b0000, 5'b00010);
                add_row(OPC_SEC, CLS_FLAG, ALU_SUM, SRC_ACC, SRC_ACC,  4'b0001, 5'b00010);
                add_row(8'h0A,   CLS_NONE, ALU_SUM, SRC_ACC, SRC_ACC,  4'b0000, 5'b00000);
                add_row(8'h00,   CLS_NONE, ALU_SUM, SRC_ACC, SRC_ACC,  4'b0000, 5'b00000);
        endtask

        // alu_done comes one to five cycles after alu_start
        task automatic model_alu();
                alu_done = 1'b0;
                if (alu_start)
                        alu_wait = 2 + int'(next_random() % 32'd5);
                if (alu_wait > 0) begin
                        alu_wait--;
                        if (alu_wait == 0) begin
                                alu_done  = 1'b1;
                                alu_fired = 1'b1;
                        end
                end
        endtask

        task automatic check_outputs();
                logic [4:0] wr;
                row_t       f;
                wr = {we_acc, we_x, we_y, we_stat, we_mem};
                if (!alu_start && wr == 5'b00000 && !instruction_done)
                        return;
                assert (pend_q.size() > 0)
                else stop_with_failure("ERROR: decoder output with no instruction in flight");
                f = pend_q[0];
                if (!first_seen && issue_q[0] >= 0) begin
                        assert (cyc - issue_q[0] == 3)
                        else value_error($sformatf("opcode %h first output %0d edges after issue",
                                f.opc, cyc - issue_q[0]));
                end
                first_seen = 1'b1;
                if (alu_start) begin
                        assert (f.cls == CLS_ALU && !started)
                        else value_error($sformatf("opcode %h raised alu_start", f.opc));
                        assert (alu_op == f.op && alu_a_sel == f.a_sel && alu_b_sel == f.b_sel &&
                                invert_b == f.inv && carry_in == f.cin)
                        else value_error($sformatf("opcode %h ALU controls %s %s %s inv %b cin %b",
                                f.opc, alu_op.name(), alu_a_sel.name(), alu_b_sel.name(),
                                invert_b, carry_in));
                        started = 1'b1;
                end
                if (wr != 5'b00000 || instruction_done) begin
                        if (f.cls == CLS_ALU) begin
                                assert (started && alu_fired && instruction_done && wr == f.wr &&
                                        update_status == f.upd && dest_sel == SRC_ALU)
                                else value_error($sformatf("opcode %h writeback %b status %b",
                                        f.opc, wr, update_status));
                        end else if (f.cls == CLS_NONE) begin
                                assert (instruction_done && wr == 5'b00000)
                                else value_error($sformatf("opcode %h unsupported, wrote %b",
                                        f.opc, wr));
                        end else if (wr != 5'b00000) begin
                                assert (!instruction_done && wr == f.wr && update_status == f.upd &&
                                        (f.cls == CLS_FLAG ? carry_value == f.cv
                                                           : dest_sel == f.b_sel))
                                else value_error($sformatf("opcode %h write %b dest %s carry %b",
                                        f.opc, wr, dest_sel.name(), carry_value));
                                write_cyc = cyc;
                        end else begin
                                assert (cyc == write_cyc + 1)
                                else value_error($sformatf("opcode %h done not right after write",
                                        f.opc));
                        end
                end
                if (instruction_done) begin
                        void'(pend_q.pop_front());
                        void'(issue_q.pop_front());
                        done_count++;
                        first_seen = 1'b0;
                        started    = 1'b0;
                        alu_fired  = 1'b0;
                        write_cyc  = -100;
                end
        endtask

        initial begin
                reset_n           = 1'b0;
                instruction_ready = 1'b0;
                instruction_in    = '0;
                alu_done          = 1'b0;
                fill_table();
                repeat (16) @(negedge clk);
                reset_n = 1'b1;
                assert (ready && !alu_start && !instruction_done && !we_acc && !we_x && !we_y &&
                        !we_stat && !we_mem && !dut_i.pd_link.valid && !dut_i.ct_link.valid)
                else value_error("outputs not idle after reset");

                while (done_count < NROWS) begin
                        @(negedge clk);
                        check_outputs();
                        model_alu();
                        instruction_ready = 1'b0;
                        if (next_row < NROWS && ready) begin
                                instruction_in    = rows[next_row].opc;
                                instruction_ready = 1'b1;
                                // Latency is only fixed when nothing is in flight
                                issue_q.push_back(pend_q.size() == 0 ? cyc : -1);
                                pend_q.push_back(rows[next_row]);
                                next_row++;
                        end
                end

                // Quiet cycles catch stray strobes
                repeat (4) begin
                        @(negedge clk);
                        check_outputs();
                end

                if (ready && !dut_i.pd_link.valid && !dut_i.ct_link.valid) begin
                        $display("*** PASSED ***");
                        $finish;
                end else begin
                        stop_with_failure("ERROR: pipeline not empty at the end of the run");
                end
        end

endmodule

// File: tb.f
+incdir+rtl
rtl/cpu_isa_pkg.sv
rtl/dec_ctrl_pkg.sv
rtl/dec_stage_if.sv
rtl/dec_predecode.sv
rtl/dec_microcode.sv
rtl/dec_sequencer.sv
rtl/decoder_top.sv
test/dec_chk.sv
test/tb_decoder.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the decoder testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_decoder -f tb.f -o sim_decoder \
        && ./obj_dir/sim_decoder | tee /dev/stderr | grep -q -F -- '*** PASSED ***' \
        && echo "decoder simulation passed" \
        || { echo "decoder simulation failed"; exit 1; }
